/* common/kf8255_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// 8255 control definitions
// Control word views, group modes and the CPU bus seen by Port C
// ~~~~~~~~~~~~~~~~~~~~

package kf8255_pkg;

    typedef enum logic {
        PORT_OUTPUT = 1'b0,
        PORT_INPUT  = 1'b1
    } port_dir_e;

    typedef enum logic {
        MODE_0 = 1'b0,
        MODE_1 = 1'b1
    } group_mode_e;

    // Control word with bit 7 set
    typedef struct packed {
        logic        flag;
        logic [1:0]  group_a_mode;
        port_dir_e   port_a_dir;
        port_dir_e   port_c_upper_dir;
        group_mode_e group_b_mode;
        port_dir_e   port_b_dir;
        port_dir_e   port_c_lower_dir;
    } mode_set_t;

    // Control word with bit 7 clear
    typedef struct packed {
        logic       flag;
        logic [2:0] unused;
        logic [2:0] bit_select;
        logic       value;
    } bit_set_t;

    typedef union packed {
        mode_set_t mode_set;
        bit_set_t  bit_set;
    } control_word_u;

    typedef struct packed {
        group_mode_e mode;
        port_dir_e   port_dir;
        port_dir_e   port_c_dir;
    } group_config_t;

    localparam group_config_t GROUP_CONFIG_RESET = '{MODE_0, PORT_INPUT, PORT_INPUT};

    typedef struct packed {
        logic [7:0] data;
        logic       write_control;
        logic       write_port_a;
        logic       write_port_b;
        logic       write_port_c;
        logic       read_port_a;
        logic       read_port_b;
    } cpu_bus_t;

endpackage

/* common/port_c_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Port C definitions
// Pin roles, handshake states and handshake status
// ~~~~~~~~~~~~~~~~~~~~

package port_c_pkg;

    // Pin roles in mode 1
    localparam int PC_INTR_B = 0;
    localparam int PC_BUF_B  = 1;
    localparam int PC_STB_B  = 2;
    localparam int PC_INTR_A = 3;
    localparam int PC_STB_A  = 4;
    localparam int PC_IBF_A  = 5;
    localparam int PC_ACK_A  = 6;
    localparam int PC_OBF_A  = 7;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        STROBED = 3'd1,
        LOADED  = 3'd2,
        WRITTEN = 3'd3,
        ACKED   = 3'd4,
        DONE    = 3'd5
    } handshake_state_e;

    typedef struct packed {
        logic ibf;
        logic obf_n;
        logic intr;
        logic strobe;
    } handshake_status_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] index;
        logic       value;
    } bit_command_t;

endpackage

/* rtl/control_word_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Control word decoder
// Holds group A/B mode registers, decodes bit set/reset words
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module control_word_decoder (
    input  logic                      clock,
    input  logic                      reset,
    input  kf8255_pkg::cpu_bus_t      bus,
    output kf8255_pkg::group_config_t group_a_config,
    output kf8255_pkg::group_config_t group_b_config,
    output port_c_pkg::bit_command_t  bit_command,
    output logic                      mode_update_a,
    output logic                      mode_update_b
);
    import kf8255_pkg::*;
    import port_c_pkg::*;

    control_word_u control_word;
    logic          mode_set_write;

    assign control_word   = bus.data;
    assign mode_set_write = bus.write_control && control_word.mode_set.flag;

    // Bit set/reset lands in the latch together with plain Port C writes
    always_comb begin
        bit_command.valid = bus.write_control && !control_word.bit_set.flag;
        bit_command.index = control_word.bit_set.bit_select;
        bit_command.value = control_word.bit_set.value;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            group_a_config <= GROUP_CONFIG_RESET;
            group_b_config <= GROUP_CONFIG_RESET;
            mode_update_a  <= 1'b0;
            mode_update_b  <= 1'b0;
        end else begin
            mode_update_a <= mode_set_write;
            mode_update_b <= mode_set_write;
            if (mode_set_write) begin
                // No mode 2 here, so 2 and 3 fall back to mode 0
                group_a_config.mode <= (control_word.mode_set.group_a_mode == 2'd1) ?
                                       MODE_1 : MODE_0;
                group_a_config.port_dir   <= control_word.mode_set.port_a_dir;
                group_a_config.port_c_dir <= control_word.mode_set.port_c_upper_dir;
                group_b_config.mode       <= control_word.mode_set.group_b_mode;
                group_b_config.port_dir   <= control_word.mode_set.port_b_dir;
                group_b_config.port_c_dir <= control_word.mode_set.port_c_lower_dir;
            end
        end
    end

endmodule

/* port_c/handshake_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Mode 1 handshake FSM
// Strobed input (IBF/INTR) or output (/OBF/INTR) for one group
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module handshake_fsm (
    input  logic                          clock,
    input  logic                          reset,
    input  kf8255_pkg::group_config_t     group_config,
    input  logic                          mode_update,
    input  logic                          write_port,
    input  logic                          read_port,
    input  logic                          stb_n,
    input  logic                          ack_n,
    input  logic                          inte,
    output port_c_pkg::handshake_status_t status
);
    import kf8255_pkg::*;
    import port_c_pkg::*;

    handshake_state_e state;
    handshake_state_e state_next;
    logic             handshake_on;
    logic             input_dir;

    assign handshake_on = (group_config.mode == MODE_1);
    assign input_dir    = (group_config.port_dir == PORT_INPUT);

    always_comb begin
        state_next = state;
        if (!handshake_on || mode_update) begin
            state_next = IDLE;
        end else if (input_dir) begin
            case (state)
                IDLE:
                    if (!stb_n)
                        state_next = STROBED;
                STROBED:
                    if (stb_n)
                        state_next = LOADED;
                LOADED:
                    if (read_port)
                        state_next = IDLE;
                default:
                    state_next = IDLE;
            endcase
        end else begin
            case (state)
                IDLE, DONE:
                    if (write_port)
                        state_next = WRITTEN;
                WRITTEN:
                    if (!ack_n)
                        state_next = ACKED;
                ACKED:
                    if (ack_n)
                        state_next = DONE;
                default:
                    state_next = IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    // Status from state only, strobe follows the pin
    always_comb begin
        status.ibf    = (state == STROBED) || (state == LOADED);
        status.obf_n  = (state != WRITTEN);
        status.intr   = inte && ((state == LOADED) || (state == DONE));
        status.strobe = handshake_on && input_dir && !stb_n;
    end

endmodule

/* port_c/port_c_latch.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Port C output latch
// Byte and bit writes, handshake pins overlaid in mode 1
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module port_c_latch (
    input  logic                          clock,
    input  logic                          reset,
    input  kf8255_pkg::cpu_bus_t          bus,
    input  port_c_pkg::bit_command_t      bit_command,
    input  kf8255_pkg::group_config_t     group_a_config,
    input  kf8255_pkg::group_config_t     group_b_config,
    input  logic                          mode_update_a,
    input  logic                          mode_update_b,
    input  port_c_pkg::handshake_status_t status_a,
    input  port_c_pkg::handshake_status_t status_b,
    output logic [7:0]                    port_c_out,
    output logic                          inte_a,
    output logic                          inte_b
);
    import kf8255_pkg::*;
    import port_c_pkg::*;

    logic [7:0] latch_q;
    logic [7:0] latch_next;

    always_comb begin
        latch_next = latch_q;
        // Group A owns PC3 to PC7, group B owns PC0 to PC2
        if (mode_update_a)
            latch_next[7:PC_INTR_A] = '0;
        if (mode_update_b)
            latch_next[PC_STB_B:0] = '0;
        if (bus.write_port_c)
            latch_next = bus.data;
        else if (bit_command.valid)
            latch_next[bit_command.index] = bit_command.value;
    end

    always_ff @(posedge clock) begin
        if (reset)
            latch_q <= 8'h00;
        else
            latch_q <= latch_next;
    end

    always_comb begin
        port_c_out = latch_q;
        if (group_b_config.mode == MODE_1) begin
            port_c_out[PC_INTR_B] = status_b.intr;
            port_c_out[PC_BUF_B]  = (group_b_config.port_dir == PORT_INPUT) ?
                                    status_b.ibf : status_b.obf_n;
        end
        if (group_a_config.mode == MODE_1) begin
            port_c_out[PC_INTR_A] = status_a.intr;
            if (group_a_config.port_dir == PORT_INPUT)
                port_c_out[PC_IBF_A] = status_a.ibf;
            else
                port_c_out[PC_OBF_A] = status_a.obf_n;
        end
    end

    // INTE bits sit behind the strobe or ack pin of each group
    assign inte_b = latch_q[PC_STB_B];
    assign inte_a = (group_a_config.port_dir == PORT_INPUT) ?
                    latch_q[PC_STB_A] : latch_q[PC_ACK_A];

endmodule

/* port_c/port_c_pin_map.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Port C pin map
// Per-pin direction from the group modes, registered readback
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module port_c_pin_map (
    input  logic                      clock,
    input  logic                      reset,
    input  kf8255_pkg::group_config_t group_a_config,
    input  kf8255_pkg::group_config_t group_b_config,
    input  logic [7:0]                port_c_out,
    input  logic [7:0]                port_c_in,
    output logic [7:0]                port_c_io,
    output logic [7:0]                port_c_read
);
    import kf8255_pkg::*;
    import port_c_pkg::*;

    always_comb begin
        port_c_io = {8{PORT_INPUT}};

        // Group B, lower half
        if (group_b_config.mode == MODE_0) begin
            port_c_io[3:0] = {4{group_b_config.port_c_dir}};
        end else begin
            port_c_io[PC_INTR_B] = PORT_OUTPUT;
            port_c_io[PC_BUF_B]  = PORT_OUTPUT;
            port_c_io[PC_STB_B]  = PORT_INPUT;
            // PC3 stays lower Port C unless group A takes it
            port_c_io[PC_INTR_A] = group_b_config.port_c_dir;
        end

        // Group A, upper half
        if (group_a_config.mode == MODE_0) begin
            port_c_io[7:4] = {4{group_a_config.port_c_dir}};
        end else if (group_a_config.port_dir == PORT_INPUT) begin
            port_c_io[PC_INTR_A] = PORT_OUTPUT;
            port_c_io[PC_STB_A]  = PORT_INPUT;
            port_c_io[PC_IBF_A]  = PORT_OUTPUT;
            port_c_io[PC_ACK_A]  = group_a_config.port_c_dir;
            port_c_io[PC_OBF_A]  = group_a_config.port_c_dir;
        end else begin
            port_c_io[PC_INTR_A] = PORT_OUTPUT;
            port_c_io[PC_STB_A]  = group_a_config.port_c_dir;
            port_c_io[PC_IBF_A]  = group_a_config.port_c_dir;
            port_c_io[PC_ACK_A]  = PORT_INPUT;
            port_c_io[PC_OBF_A]  = PORT_OUTPUT;
        end
    end

    // Input pins read 1 in port_c_io, so it selects the pin level directly
    always_ff @(posedge clock) begin
        if (reset)
            port_c_read <= 8'h00;
        else
            port_c_read <= (port_c_in & port_c_io) | (port_c_out & ~port_c_io);
    end

endmodule

/* rtl/kf8255_port_c_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// 8255 Port C top level
// Control decode, group A/B handshakes, output latch and pin map
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module kf8255_port_c_top (
    input  logic                 clock,
    input  logic                 reset,
    input  kf8255_pkg::cpu_bus_t bus,
    input  logic [7:0]           port_c_in,
    output logic [7:0]           port_c_out,
    output logic [7:0]           port_c_io,
    output logic [7:0]           port_c_read,
    output logic                 port_a_strobe,
    output logic                 port_b_strobe
);
    import kf8255_pkg::*;
    import port_c_pkg::*;

    group_config_t     group_a_config;
    group_config_t     group_b_config;
    bit_command_t      bit_command;
    logic              mode_update_a;
    logic              mode_update_b;
    handshake_status_t status_a;
    handshake_status_t status_b;
    logic              inte_a;
    logic              inte_b;

    control_word_decoder decoder (
        .clock          (clock),
        .reset          (reset),
        .bus            (bus),
        .group_a_config (group_a_config),
        .group_b_config (group_b_config),
        .bit_command    (bit_command),
        .mode_update_a  (mode_update_a),
        .mode_update_b  (mode_update_b)
    );

    handshake_fsm handshake_a (
        .clock        (clock),
        .reset        (reset),
        .group_config (group_a_config),
        .mode_update  (mode_update_a),
        .write_port   (bus.write_port_a),
        .read_port    (bus.read_port_a),
        .stb_n        (port_c_in[PC_STB_A]),
        .ack_n        (port_c_in[PC_ACK_A]),
        .inte         (inte_a),
        .status       (status_a)
    );

    // Group B shares one pin for strobe and acknowledge
    handshake_fsm handshake_b (
        .clock        (clock),
        .reset        (reset),
        .group_config (group_b_config),
        .mode_update  (mode_update_b),
        .write_port   (bus.write_port_b),
        .read_port    (bus.read_port_b),
        .stb_n        (port_c_in[PC_STB_B]),
        .ack_n        (port_c_in[PC_STB_B]),
        .inte         (inte_b),
        .status       (status_b)
    );

    port_c_latch latch (
        .clock          (clock),
        .reset          (reset),
        .bus            (bus),
        .bit_command    (bit_command),
        .group_a_config (group_a_config),
        .group_b_config (group_b_config),
        .mode_update_a  (mode_update_a),
        .mode_update_b  (mode_update_b),
        .status_a       (status_a),
        .status_b       (status_b),
        .port_c_out     (port_c_out),
        .inte_a         (inte_a),
        .inte_b         (inte_b)
    );

    port_c_pin_map pin_map (
        .clock          (clock),
        .reset          (reset),
        .group_a_config (group_a_config),
        .group_b_config (group_b_config),
        .port_c_out     (port_c_out),
        .port_c_in      (port_c_in),
        .port_c_io      (port_c_io),
        .port_c_read    (port_c_read)
    );

    assign port_a_strobe = status_a.strobe;
    assign port_b_strobe = status_b.strobe;

endmodule

/* verification/port_c_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Port C assertions
// Reset directions, INTR clear on mode set, strobes idle in mode 0
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module port_c_properties (
    input logic                      clock,
    input logic                      reset,
    input kf8255_pkg::cpu_bus_t      bus,
    input kf8255_pkg::group_config_t group_a_config,
    input kf8255_pkg::group_config_t group_b_config,
    input logic                      mode_update_a,
    input logic                      mode_update_b,
    input logic [7:0]                port_c_out,
    input logic [7:0]                port_c_io,
    input logic                      port_a_strobe,
    input logic                      port_b_strobe
);
    import kf8255_pkg::*;
    import port_c_pkg::*;

    reset_all_inputs: assert property (@(posedge clock) reset |=> port_c_io == 8'hFF)
        else $error("Port C pins are not all inputs after reset");

    // Only when no write lands in the same cycle as the update
    intr_a_cleared: assert property (@(posedge clock) disable iff (reset)
        mode_update_a && !bus.write_port_c && !bus.write_control |=> !port_c_out[PC_INTR_A])
        else $error("PC3 INTR still high after a mode update");

    intr_b_cleared: assert property (@(posedge clock) disable iff (reset)
        mode_update_b && !bus.write_port_c && !bus.write_control |=> !port_c_out[PC_INTR_B])
        else $error("PC0 INTR still high after a mode update");

    strobe_a_idle: assert property (@(posedge clock) disable iff (reset)
        group_a_config.mode == MODE_0 |-> !port_a_strobe)
        else $error("Port A strobe high in mode 0");

    strobe_b_idle: assert property (@(posedge clock) disable iff (reset)
        group_b_config.mode == MODE_0 |-> !port_b_strobe)
        else $error("Port B strobe high in mode 0");

endmodule

bind kf8255_port_c_top port_c_properties properties0 (
    .clock          (clock),
    .reset          (reset),
    .bus            (bus),
    .group_a_config (group_a_config),
    .group_b_config (group_b_config),
    .mode_update_a  (mode_update_a),
    .mode_update_b  (mode_update_b),
    .port_c_out     (port_c_out),
    .port_c_io      (port_c_io),
    .port_a_strobe  (port_a_strobe),
    .port_b_strobe  (port_b_strobe)
);

/* verification/tb_port_c_model.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Port C reference model
// Cycle model of latch, group configs, handshakes and readback
// ~~~~~~~~~~~~~~~~~~~~

`ifndef TB_PORT_C_MODEL_SVH
`define TB_PORT_C_MODEL_SVH

logic [7:0]       model_latch;
logic [7:0]       model_read;
group_config_t    model_cfg_a;
group_config_t    model_cfg_b;
logic             model_update;
handshake_state_e model_state_a;
handshake_state_e model_state_b;

function automatic logic holds_data(handshake_state_e s);
    return (s == STROBED) || (s == LOADED);
endfunction

function automatic logic raises_intr(handshake_state_e s);
    return (s == LOADED) || (s == DONE);
endfunction

function automatic handshake_state_e step_handshake(handshake_state_e s, group_config_t cfg,
        logic update, logic stb_n, logic ack_n, logic write_port, logic read_port);
    if (cfg.mode == MODE_0 || update)
        return IDLE;
    if (cfg.port_dir == PORT_INPUT) begin
        if (s == IDLE && !stb_n)
            return STROBED;
        if (s == STROBED && stb_n)
            return LOADED;
        if (s == LOADED && read_port)
            return IDLE;
    end else begin
        if ((s == IDLE || s == DONE) && write_port)
            return WRITTEN;
        if (s == WRITTEN && !ack_n)
            return ACKED;
        if (s == ACKED && ack_n)
            return DONE;
    end
    return s;
endfunction

// Input pins read as 1
function automatic logic [7:0] expected_io();
    logic [7:0] io;
    io = {{4{model_cfg_a.port_c_dir}}, {4{model_cfg_b.port_c_dir}}};
    if (model_cfg_b.mode == MODE_1)
        io[2:0] = 3'b100;
    if (model_cfg_a.mode == MODE_1) begin
        io[3] = 1'b0;
        if (model_cfg_a.port_dir == PORT_INPUT)
            io[5:4] = 2'b01;
        else
            io[7:6] = 2'b01;
    end
    return io;
endfunction

function automatic logic [7:0] expected_out();
    logic [7:0] v;
    logic       inte_a;
    v = model_latch;
    inte_a = (model_cfg_a.port_dir == PORT_INPUT) ? model_latch[4] : model_latch[6];
    if (model_cfg_b.mode == MODE_1) begin
        v[0] = model_latch[2] && raises_intr(model_state_b);
        if (model_cfg_b.port_dir == PORT_INPUT)
            v[1] = holds_data(model_state_b);
        else
            v[1] = (model_state_b != WRITTEN);
    end
    if (model_cfg_a.mode == MODE_1) begin
        v[3] = inte_a && raises_intr(model_state_a);
        if (model_cfg_a.port_dir == PORT_INPUT)
            v[5] = holds_data(model_state_a);
        else
            v[7] = (model_state_a != WRITTEN);
    end
    return v;
endfunction

// Strobe outputs as {group A, group B}
function automatic logic [1:0] expected_strobes(logic [7:0] pins);
    logic [1:0] s;
    s[1] = model_cfg_a.mode == MODE_1 && model_cfg_a.port_dir == PORT_INPUT && !pins[4];
    s[0] = model_cfg_b.mode == MODE_1 && model_cfg_b.port_dir == PORT_INPUT && !pins[2];
    return s;
endfunction

// Everything the DUT registers at one rising edge
function automatic void model_clock(cpu_bus_t b, logic [7:0] pins, logic rst);
    logic [7:0] io;
    logic [7:0] out;
    logic [7:0] latch_next;
    if (rst) begin
        model_latch   = 8'h00;
        model_read    = 8'h00;
        model_cfg_a   = group_config_t'(3'b011);
        model_cfg_b   = group_config_t'(3'b011);
        model_update  = 1'b0;
        model_state_a = IDLE;
        model_state_b = IDLE;
        return;
    end
    io  = expected_io();
    out = expected_out();
    for (int i = 0; i < 8; i++)
        model_read[i] = io[i] ? pins[i] : out[i];
    model_state_a = step_handshake(model_state_a, model_cfg_a, model_update,
                                   pins[4], pins[6], b.write_port_a, b.read_port_a);
    model_state_b = step_handshake(model_state_b, model_cfg_b, model_update,
                                   pins[2], pins[2], b.write_port_b, b.read_port_b);
    // Both groups take the update together
    latch_next = model_update ? 8'h00 : model_latch;
    if (b.write_port_c)
        latch_next = b.data;
    else if (b.write_control && !b.data[7])
        latch_next[b.data[3:1]] = b.data[0];
    model_latch  = latch_next;
    model_update = b.write_control && b.data[7];
    if (model_update) begin
        model_cfg_a = group_config_t'({b.data[6:5] == 2'b01, b.data[4], b.data[3]});
        model_cfg_b = group_config_t'(b.data[2:0]);
    end
endfunction

`endif

/* verification/tb_port_c.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Port C testbench
// Random and directed stimulus checked against a cycle model
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_port_c;
    import kf8255_pkg::*;
    import port_c_pkg::*;

    localparam int MODE0_OPS        = 64;
    localparam int DIR_OPS          = 32;
    localparam int SCHEDULED_CYCLES = 12 + MODE0_OPS + 4 * DIR_OPS + 40;
    localparam int TIMEOUT_CYCLES   = 4 * SCHEDULED_CYCLES;

    // Bus strobes in cpu_bus_t order
    localparam logic [5:0] STB_CONTROL = 6'b100000;
    localparam logic [5:0] STB_WRITE_A = 6'b010000;
    localparam logic [5:0] STB_WRITE_C = 6'b000100;
    localparam logic [5:0] STB_READ_B  = 6'b000001;

    logic        clock = 1'b0;
    logic        reset;
    cpu_bus_t    bus;
    logic [7:0]  port_c_in;
    logic [7:0]  port_c_out;
    logic [7:0]  port_c_io;
    logic [7:0]  port_c_read;
    logic        port_a_strobe;
    logic        port_b_strobe;
    logic [31:0] rng_state = 32'h9026_9ab6;
    int          cycle_count = 0;
    int          error_count = 0;

    `include "tb_port_c_model.svh"

    kf8255_port_c_top dut0 (
        .clock         (clock),
        .reset         (reset),
        .bus           (bus),
        .port_c_in     (port_c_in),
        .port_c_out    (port_c_out),
        .port_c_io     (port_c_io),
        .port_c_read   (port_c_read),
        .port_a_strobe (port_a_strobe),
        .port_b_strobe (port_b_strobe)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES));
    end

    function automatic logic [7:0] random_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:24];
    endfunction

    task automatic abort_run(string reason);
        error_count++;
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_byte(string test_name, logic [7:0] expected, logic [7:0] actual);
        if (expected !== actual)
            abort_run($sformatf("[FAIL] %s expected %02h actual %02h",
                                test_name, expected, actual));
    endtask

    task automatic check_status(string test_name, logic [1:0] expected, logic [1:0] actual);
        if (expected !== actual)
            abort_run($sformatf("[FAIL] %s strobes expected %b actual %b",
                                test_name, expected, actual));
    endtask

    // One clock, then every output against the model
    task automatic advance(string test_name);
        @(negedge clock);
        model_clock(bus, port_c_in, reset);
        if (!reset) begin
            check_byte({test_name, " out"}, expected_out(), port_c_out);
            check_byte({test_name, " io"}, expected_io(), port_c_io);
            check_byte({test_name, " read"}, model_read, port_c_read);
            check_status(test_name, expected_strobes(port_c_in),
                         {port_a_strobe, port_b_strobe});
        end
    endtask

    task automatic send(string test_name, logic [7:0] data, logic [5:0] strobes);
        bus = {data, strobes};
        advance(test_name);
        bus = '0;
    endtask

    task automatic wait_for_pin(string test_name, int pin, logic value);
        int waited = 0;
        while (port_c_out[pin] !== value) begin
            if (waited == 8) begin
                abort_run($sformatf("%s: PC%0d did not reach %b within 8 cycles",
                                    test_name, pin, value));
            end else begin
                advance(test_name);
                waited++;
            end
        end
    endtask

    initial begin
        logic [7:0] word;
        reset = 1'b1;
        bus = '0;
        port_c_in = 8'hFF;
        repeat (10) advance("reset");
        check_byte("reset out", 8'h00, port_c_out);
        check_byte("reset io", 8'hFF, port_c_io);
        check_byte("reset read", 8'h00, port_c_read);
        check_status("reset", 2'b00, {port_a_strobe, port_b_strobe});
        reset = 1'b0;
        advance("reset release");

        // Lower half driven, upper half read from the pins
        send("mode 0 setup", 8'h88, STB_CONTROL);
        for (int i = 0; i < MODE0_OPS; i++) begin
            port_c_in = random_byte();
            word = random_byte();
            if (word[7])
                send("mode 0 write", random_byte(), STB_WRITE_C);
            else
                send("mode 0 bit set", {1'b0, word[6:0]}, STB_CONTROL);
        end

        // Mode sets, then random port strobes and pins
        for (int i = 0; i < DIR_OPS; i++) begin
            word = random_byte();
            port_c_in = random_byte();
            send("direction map", {1'b1, word[6:0]}, STB_CONTROL);
            repeat (3) begin
                port_c_in = random_byte();
                word = random_byte();
                send("direction map", random_byte(), word[5:0] & 6'b011111);
            end
        end

        // Group B mode 1 input, INTE B on PC2
        port_c_in = 8'hFF;
        send("group b setup", 8'h86, STB_CONTROL);
        send("group b setup", 8'h05, STB_CONTROL);
        advance("group b setup");
        port_c_in[PC_STB_B] = 1'b0;
        advance("group b strobe");
        check_status("group b strobe", 2'b01, {port_a_strobe, port_b_strobe});
        check_byte("group b ibf", 8'h02, port_c_out & 8'h03);
        port_c_in[PC_STB_B] = 1'b1;
        wait_for_pin("group b intr", PC_INTR_B, 1'b1);
        send("group b read", 8'h00, STB_READ_B);
        check_byte("group b cleared", 8'h00, port_c_out & 8'h03);

        // Group A mode 1 output, INTE A on PC6
        send("group a setup", 8'hA8, STB_CONTROL);
        send("group a setup", 8'h0D, STB_CONTROL);
        advance("group a setup");
        send("group a write", random_byte(), STB_WRITE_A);
        check_byte("group a obf low", 8'h00, port_c_out & 8'h88);
        port_c_in[PC_ACK_A] = 1'b0;
        advance("group a ack");
        check_byte("group a obf high", 8'h80, port_c_out & 8'h88);
        port_c_in[PC_ACK_A] = 1'b1;
        wait_for_pin("group a intr", PC_INTR_A, 1'b1);
        send("group a next write", random_byte(), STB_WRITE_A);
        check_byte("group a intr cleared", 8'h00, port_c_out & 8'h88);
        advance("drain");

        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+verification
common/kf8255_pkg.sv
common/port_c_pkg.sv
rtl/control_word_decoder.sv
port_c/handshake_fsm.sv
port_c/port_c_latch.sv
port_c/port_c_pin_map.sv
rtl/kf8255_port_c_top.sv
verification/port_c_properties.sv
verification/tb_port_c.sv

/* Makefile */
TOP := tb_port_c

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '=== PASS ==='

clean:
	rm -rf obj_dir
